//--- list.f
lsu_pkg.sv
lsu_req_decode.sv
lsu_axi_master.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

//--- lsu_axi_master.sv
`default_nettype none

module lsu_axi_master import lsu_pkg::*; (
    input  wire           clk,
    input  wire           rst,

    // Command from decode
    input  wire           cmd_valid,
    input  wire mem_cmd_t cmd,
    output logic          cmd_ready,

    // Response to load align
    input  wire           rsp_ready,
    output logic          rsp_valid,
    output logic [31:0]   rsp_data,
    output logic          rsp_fault,
    output mem_cmd_t      rsp_cmd,

    // AXI4 master
    output logic          ar_valid,
    input  wire           ar_ready,
    output axi_ax_t       ar,
    output logic          aw_valid,
    input  wire           aw_ready,
    output axi_ax_t       aw,
    output logic          w_valid,
    input  wire           w_ready,
    output axi_w_t        w,
    input  wire           b_valid,
    output logic          b_ready,
    input  wire axi_b_t   b,
    input  wire           r_valid,
    output logic          r_ready,
    input  wire axi_r_t   r
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_ADDR,
        S_RD_DATA,
        S_WRITE,
        S_WR_RESP,
        S_DONE
    } state_e;

    state_e      state;
    mem_cmd_t    cmd_q;
    logic        aw_done;
    logic        w_done;
    logic        fault_q;
    logic [31:0] data_q;
    logic        take;
    logic        aw_fire;
    logic        w_fire;
    axi_ax_t     ax;

    // Idle and nothing waiting downstream
    assign cmd_ready = (state == S_IDLE) && rsp_ready;
    assign take      = cmd_valid && cmd_ready;

    // ==============================
    // AXI channel drive
    // ==============================

    assign ar_valid = (state == S_RD_ADDR);
    assign r_ready  = (state == S_RD_DATA);
    assign aw_valid = (state == S_WRITE) && !aw_done;
    assign w_valid  = (state == S_WRITE) && !w_done;
    assign b_ready  = (state == S_WR_RESP);  // Both AW and W done

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    assign ax = '{addr: cmd_q.addr, id: AXI_ID, len: AXI_LEN_SINGLE,
                  size: cmd_q.size, burst: cmd_q.burst};
    assign ar = ax;
    assign aw = ax;
    assign w  = '{data: cmd_q.wdata, strb: cmd_q.strb, last: 1'b1};

    assign rsp_cmd = cmd_q;

    // Response passes straight through on the R or B beat
    always_comb begin
        rsp_valid = 1'b0;
        rsp_data  = data_q;
        rsp_fault = fault_q;
        case (state)
            S_RD_DATA: begin
                rsp_valid = r_valid;
                rsp_data  = r.data;
                rsp_fault = (r.resp != AXI_RESP_OKAY);
            end
            S_WR_RESP: begin
                rsp_valid = b_valid;
                rsp_fault = (b.resp != AXI_RESP_OKAY);
            end
            S_DONE:  rsp_valid = 1'b1;
            default: rsp_valid = 1'b0;
        endcase
    end

    // ==============================
    // FSM
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (take) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        fault_q <= 1'b0;
                        case (cmd.op)
                            OP_LOAD:  state <= S_RD_ADDR;
                            OP_STORE: state <= S_WRITE;
                            default:  state <= S_DONE;  // Pass-through
                        endcase
                    end
                end
                S_RD_ADDR: begin
                    if (ar_ready) begin
                        state <= S_RD_DATA;
                    end
                end
                S_RD_DATA: begin
                    if (r_valid) begin
                        fault_q <= rsp_fault;
                        state   <= rsp_ready ? S_IDLE : S_DONE;
                    end
                end
                S_WRITE: begin
                    if (aw_fire) aw_done <= 1'b1;
                    if (w_fire) w_done <= 1'b1;
                    // AW and W may finish in either order
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= S_WR_RESP;
                    end
                end
                S_WR_RESP: begin
                    if (b_valid) begin
                        fault_q <= rsp_fault;
                        state   <= rsp_ready ? S_IDLE : S_DONE;
                    end
                end
                S_DONE: begin
                    if (rsp_ready) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd_q <= cmd;
        end
        if ((state == S_RD_DATA) && r_valid) begin
            data_q <= r.data;
        end
    end

endmodule

`default_nettype wire

//--- lsu_load_align.sv
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           rsp_valid,
    input  wire [31:0]    rsp_data,
    input  wire           rsp_fault,
    input  wire mem_cmd_t rsp_cmd,
    output logic          rsp_ready,
    output logic          lsu_valid,
    input  wire           wb_ready,
    output wb_t           wb
);

    logic [31:0] shifted;
    logic [31:0] load_data;
    wb_t         wb_d;

    // ==============================
    // Load extraction
    // ==============================

    always_comb begin
        shifted = rsp_data >> {rsp_cmd.offset, 3'b000};
        case (rsp_cmd.size)
            SIZE_BYTE: begin
                if (rsp_cmd.load_unsigned) begin
                    load_data = {24'h0, shifted[7:0]};
                end else begin
                    load_data = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (rsp_cmd.load_unsigned) begin
                    load_data = {16'h0, shifted[15:0]};
                end else begin
                    load_data = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: load_data = shifted;
        endcase
    end

    // Stores and pass-through ops write back the execute result
    always_comb begin
        wb_d.rd    = rsp_cmd.rd;
        wb_d.data  = (rsp_cmd.op == OP_LOAD) ? load_data : rsp_cmd.result;
        wb_d.fault = rsp_fault;
    end

    // ==============================
    // Writeback register
    // ==============================

    assign rsp_ready = !lsu_valid;  // Free once the held result is gone

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsu_valid <= 1'b0;
        end else if (rsp_valid && rsp_ready) begin
            lsu_valid <= 1'b1;
        end else if (wb_ready) begin
            lsu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid && rsp_ready) begin
            wb <= wb_d;
        end
    end

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ==============================
    // Encodings
    // ==============================

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,  // Result passes through
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } lsu_op_e;

    // Values match the AXI AxSIZE codes
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_e;

    localparam logic [3:0] AXI_ID         = 4'h0;
    localparam logic [7:0] AXI_LEN_SINGLE = 8'h00;  // One beat per transaction
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    // ==============================
    // Records
    // ==============================

    typedef struct packed {
        lsu_op_e     op;
        mem_size_e   size;
        logic        load_unsigned;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [4:0]  rd;
        logic [31:0] result;
    } ex_req_t;

    typedef struct packed {
        lsu_op_e     op;
        mem_size_e   size;
        logic        load_unsigned;
        logic [31:0] addr;
        logic [31:0] wdata;   // Already in the addressed lanes
        logic [3:0]  strb;
        axi_burst_e  burst;
        logic [1:0]  offset;
        logic [4:0]  rd;
        logic [31:0] result;
    } mem_cmd_t;

    // Shared by AR and AW
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        mem_size_e   size;
        axi_burst_e  burst;
    } axi_ax_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        fault;
    } wb_t;

endpackage

`default_nettype wire

//--- lsu_req_decode.sv
`default_nettype none

module lsu_req_decode import lsu_pkg::*; #(
    parameter logic [31:0] SDRAM_BASE = 32'hA000_0000,
    parameter logic [31:0] SDRAM_END  = 32'hBFFF_FFFF
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          ex_valid,
    input  wire ex_req_t ex_req,
    input  wire          cmd_ready,
    output logic         lsu_ready,
    output logic         cmd_valid,
    output mem_cmd_t     cmd
);

    logic       started;   // Low until the first edge after reset
    logic       full;
    logic [1:0] offset;
    logic [3:0] mask;
    logic       in_sdram;
    mem_cmd_t   cmd_d;

    assign offset   = ex_req.addr[1:0];
    assign in_sdram = (ex_req.addr >= SDRAM_BASE) && (ex_req.addr <= SDRAM_END);

    // Width mask before lane shift
    always_comb begin
        case (ex_req.size)
            SIZE_BYTE: mask = 4'b0001;
            SIZE_HALF: mask = 4'b0011;
            default:   mask = 4'b1111;
        endcase
    end

    always_comb begin
        cmd_d.op            = ex_req.op;
        cmd_d.size          = ex_req.size;
        cmd_d.load_unsigned = ex_req.load_unsigned;
        cmd_d.addr          = ex_req.addr;
        cmd_d.wdata         = ex_req.wdata << {offset, 3'b000};
        cmd_d.strb          = (ex_req.op == OP_STORE) ? (mask << offset) : 4'b0000;
        cmd_d.burst         = in_sdram ? BURST_INCR : BURST_FIXED;
        cmd_d.offset        = offset;
        cmd_d.rd            = ex_req.rd;
        cmd_d.result        = ex_req.result;
    end

    // cmd_ready already folds in the master and writeback side
    assign lsu_ready = started && !full && cmd_ready;
    assign cmd_valid = full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
            full    <= 1'b0;
        end else begin
            started <= 1'b1;
            if (ex_valid && lsu_ready) begin
                full <= 1'b1;
            end else if (cmd_valid && cmd_ready) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && lsu_ready) begin
            cmd <= cmd_d;
        end
    end

endmodule

`default_nettype wire

//--- lsu_top.sv
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter logic [31:0] SDRAM_BASE = 32'hA000_0000,
    parameter logic [31:0] SDRAM_END  = 32'hBFFF_FFFF
) (
    input  wire          clk,
    input  wire          rst,

    // Execute side
    input  wire          ex_valid,
    input  wire ex_req_t ex_req,
    output logic         lsu_ready,

    // Writeback side
    output logic         lsu_valid,
    output wb_t          wb,
    input  wire          wb_ready,

    // AXI4 master
    output logic         ar_valid,
    input  wire          ar_ready,
    output axi_ax_t      ar,
    output logic         aw_valid,
    input  wire          aw_ready,
    output axi_ax_t      aw,
    output logic         w_valid,
    input  wire          w_ready,
    output axi_w_t       w,
    input  wire          b_valid,
    output logic         b_ready,
    input  wire axi_b_t  b,
    input  wire          r_valid,
    output logic         r_ready,
    input  wire axi_r_t  r
);

    logic        cmd_valid;
    logic        cmd_ready;
    mem_cmd_t    cmd;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_data;
    logic        rsp_fault;
    mem_cmd_t    rsp_cmd;

    lsu_req_decode #(
        .SDRAM_BASE (SDRAM_BASE),
        .SDRAM_END  (SDRAM_END)
    ) i_lsu_req_decode (
        .clk, .rst,
        .ex_valid, .ex_req, .cmd_ready,
        .lsu_ready, .cmd_valid, .cmd
    );

    lsu_axi_master i_lsu_axi_master (
        .clk, .rst,
        .cmd_valid, .cmd, .cmd_ready,
        .rsp_ready, .rsp_valid, .rsp_data, .rsp_fault, .rsp_cmd,
        .ar_valid, .ar_ready, .ar,
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .b_valid, .b_ready, .b,
        .r_valid, .r_ready, .r
    );

    lsu_load_align i_lsu_load_align (
        .clk, .rst,
        .rsp_valid, .rsp_data, .rsp_fault, .rsp_cmd, .rsp_ready,
        .lsu_valid, .wb_ready, .wb
    );

endmodule

`default_nettype wire

//--- tb_lsu.sv
`default_nettype none

module tb_lsu import lsu_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    // Test address map
    localparam logic [31:0] SDRAM_BASE = 32'hA000_0000;
    localparam logic [31:0] SDRAM_END  = 32'hBFFF_FFFF;
    localparam logic [31:0] SDRAM_ADDR = 32'hA000_0100;
    localparam logic [31:0] IO_ADDR    = 32'h1000_0200;
    localparam logic [31:0] ERR_BASE   = 32'h3000_0000;
    localparam logic [31:0] ERR_END    = 32'h3000_00FF;
    localparam int          NUM_TX     = 48;
    localparam int          TX_CYCLES  = 100;   // Generous bound per transaction

    typedef struct packed {
        lsu_op_e     op;
        mem_size_e   size;
        logic [31:0] addr;
        logic [31:0] lanes;
        logic [3:0]  strb;
        axi_burst_e  burst;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        fault;
    } exp_t;

    logic    clk, rst, ex_valid, lsu_ready, lsu_valid, wb_ready;
    ex_req_t ex_req;
    wb_t     wb, wb_prev;
    logic    ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic    b_valid, b_ready, r_valid, r_ready;
    axi_ax_t ar, aw, ar_prev, aw_prev;
    axi_w_t  w, w_prev;
    axi_b_t  b;
    axi_r_t  r;

    logic [31:0] seed;
    logic [31:0] ref_mem [logic [31:0]];
    exp_t        exp_q [$];
    int          cycle, since_rst, acc_cycle;
    int          n_pt, n_store, n_load, n_fault, n_clean, n_hold;
    logic        hold_prev, lsu_prev, ar_wait, aw_wait, w_wait, rsp_fire_prev;
    logic        rst_seen, wb_ready_next;

    lsu_top #(.SDRAM_BASE(SDRAM_BASE), .SDRAM_END(SDRAM_END)) i_lsu_top (.*);

    tb_lsu_mem #(.ERR_BASE(ERR_BASE), .ERR_END(ERR_END)) i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            seed = {seed[30:0], seed[31] ^ seed[21] ^ seed[1] ^ seed[0]};
            v    = {v[30:0], seed[0]};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // ==============================
    // Reference model
    // ==============================

    function automatic exp_t build_exp(input ex_req_t q);
        exp_t        e;
        logic [31:0] key, word;
        int          n, lane;
        e     = '0;
        key   = {q.addr[31:2], 2'b00};
        n     = (q.size == SIZE_BYTE) ? 1 : (q.size == SIZE_HALF) ? 2 : 4;
        e.op  = q.op;
        e.size = q.size;
        e.addr = q.addr;
        e.rd   = q.rd;
        e.data = (q.op == OP_LOAD) ? 32'h0 : q.result;
        e.fault = (q.op != OP_NONE) && (q.addr >= ERR_BASE) && (q.addr <= ERR_END);
        e.burst = (q.addr >= SDRAM_BASE && q.addr <= SDRAM_END) ? BURST_INCR : BURST_FIXED;
        word = ref_mem.exists(key) ? ref_mem[key] : 32'h0;
        for (int i = 0; i < n; i++) begin
            lane = q.addr[1:0] + i;
            if (lane < 4) begin
                e.lanes[lane*8 +: 8] = q.wdata[i*8 +: 8];
                if (q.op == OP_STORE) e.strb[lane] = 1'b1;
                if (q.op == OP_LOAD) e.data[i*8 +: 8] = word[lane*8 +: 8];
                if (q.op == OP_STORE) word[lane*8 +: 8] = q.wdata[i*8 +: 8];
            end
        end
        if (q.op == OP_LOAD && n < 4 && !q.load_unsigned && e.data[n*8-1]) begin
            for (int k = n * 8; k < 32; k++) e.data[k] = 1'b1;
        end
        if (q.op == OP_STORE && !e.fault) ref_mem[key] = word;
        return e;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) m[i*8 +: 8] = {8{strb[i]}};
        return m;
    endfunction

    task automatic check_ax(input string name, input axi_ax_t ax, input exp_t e);
        assert (ax.addr == e.addr) else report_mismatch({name, ".addr"}, ax.addr, e.addr);
        assert (ax.size == e.size) else report_mismatch({name, ".size"}, ax.size, e.size);
        assert (ax.burst == e.burst) else report_mismatch({name, ".burst"}, ax.burst, e.burst);
        assert (ax.len == 8'h0) else report_mismatch({name, ".len"}, ax.len, 0);
        assert (ax.id == 4'h0) else report_mismatch({name, ".id"}, ax.id, 0);
    endtask

    // ==============================
    // Monitor and checks
    // ==============================

    always @(posedge clk) begin
        exp_t e;
        if (rst) begin
            // DUT state is known from the second reset edge on
            if (rst_seen) begin
                assert (!lsu_ready && !lsu_valid && !ar_valid && !aw_valid && !w_valid
                        && !b_ready && !r_ready)
                    else report_error("valid or ready high during reset");
            end
            rst_seen  = 1'b1;
            since_rst = 0;
        end else begin
            since_rst++;
            cycle++;
            if (since_rst == 2) assert (lsu_ready) else report_mismatch("lsu_ready", 0, 1);
            if (hold_prev) begin
                assert (lsu_valid) else report_error("lsu_valid dropped without wb_ready");
                assert (wb == wb_prev) else report_mismatch("wb", wb, wb_prev);
                n_hold++;
            end
            if (lsu_valid) assert (!lsu_ready) else report_error("lsu_ready high with result held");
            if (ar_wait) begin
                assert (ar_valid && ar == ar_prev) else report_error("AR changed before ready");
            end
            if (aw_wait) begin
                assert (aw_valid && aw == aw_prev) else report_error("AW changed before ready");
            end
            if (w_wait) begin
                assert (w_valid && w == w_prev) else report_error("W changed before ready");
            end
            if (rsp_fire_prev) assert (lsu_valid) else report_error("no result after R or B beat");
            if (ar_valid || aw_valid || w_valid) begin
                assert (exp_q.size() > 0) else report_error("AXI valid with no request");
                assert (exp_q[0].op != OP_NONE) else report_error("AXI valid on pass-through");
                if (ar_valid) check_ax("ar", ar, exp_q[0]);
                if (aw_valid) check_ax("aw", aw, exp_q[0]);
                if (w_valid) begin
                    e = exp_q[0];
                    assert (w.strb == e.strb) else report_mismatch("w.strb", w.strb, e.strb);
                    assert ((w.data & lane_mask(e.strb)) == (e.lanes & lane_mask(e.strb)))
                        else report_mismatch("w.data", w.data, e.lanes);
                    assert (w.last) else report_mismatch("w.last", w.last, 1);
                end
            end
            if (lsu_valid && !lsu_prev && exp_q.size() > 0 && exp_q[0].op == OP_NONE) begin
                assert (cycle - acc_cycle == 3)
                    else report_mismatch("pass-through latency", cycle - acc_cycle, 3);
            end
            if (lsu_valid && wb_ready) begin
                assert (exp_q.size() > 0) else report_error("writeback with no request outstanding");
                e = exp_q.pop_front();
                assert (wb.rd == e.rd) else report_mismatch("wb.rd", wb.rd, e.rd);
                assert (wb.fault == e.fault) else report_mismatch("wb.fault", wb.fault, e.fault);
                if (!(e.op == OP_LOAD && e.fault)) begin
                    assert (wb.data == e.data) else report_mismatch("wb.data", wb.data, e.data);
                end
                case (e.op)
                    OP_NONE:  n_pt++;
                    OP_STORE: n_store++;
                    default:  n_load++;
                endcase
                if (e.fault) n_fault++;
                else if (e.op != OP_NONE) n_clean++;
            end
            if (ex_valid && lsu_ready) begin
                exp_q.push_back(build_exp(ex_req));
                acc_cycle = cycle;
            end
        end
        hold_prev     = lsu_valid && !wb_ready;
        lsu_prev      = lsu_valid;
        wb_prev       = wb;
        ar_wait       = ar_valid && !ar_ready;
        aw_wait       = aw_valid && !aw_ready;
        w_wait        = w_valid && !w_ready;
        ar_prev       = ar;
        aw_prev       = aw;
        w_prev        = w;
        rsp_fire_prev = (r_valid && r_ready) || (b_valid && b_ready);
    end

    always @(posedge clk) wb_ready_next = 1'(take_bits(1));

    always @(negedge clk) wb_ready = rst ? 1'b0 : wb_ready_next;

    // ==============================
    // Stimulus
    // ==============================

    task automatic send(input lsu_op_e op, input mem_size_e size, input logic uns,
                        input logic [31:0] addr, input logic [31:0] wdata);
        ex_req_t q;
        q = '{op: op, size: size, load_unsigned: uns, addr: addr, wdata: wdata,
              rd: 5'(take_bits(5)), result: take_bits(32)};
        @(negedge clk);
        ex_valid = 1'b1;
        ex_req   = q;
        @(posedge clk);
        while (!lsu_ready) @(posedge clk);
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] bases [2];
        seed      = 32'h80b7;
        rst       = 1'b1;
        rst_seen  = 1'b0;
        ex_valid  = 1'b0;
        ex_req    = '0;
        wb_ready  = 1'b0;
        cycle     = 0;
        since_rst = 0;
        bases     = '{SDRAM_ADDR, IO_ADDR};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) send(OP_NONE, SIZE_WORD, 1'b0, take_bits(32), 32'h0);
        foreach (bases[j]) begin
            send(OP_STORE, SIZE_WORD, 1'b0, bases[j], take_bits(32));
            for (int off = 0; off < 4; off++) begin
                send(OP_STORE, SIZE_BYTE, 1'b0, bases[j] + off, take_bits(32));
            end
            send(OP_NONE, SIZE_WORD, 1'b0, bases[j], 32'h0);
            for (int off = 0; off < 4; off += 2) begin
                send(OP_STORE, SIZE_HALF, 1'b0, bases[j] + off, take_bits(32));
            end
            for (int off = 0; off < 4; off++) begin
                send(OP_LOAD, SIZE_BYTE, 1'b0, bases[j] + off, 32'h0);
                send(OP_LOAD, SIZE_BYTE, 1'b1, bases[j] + off, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                send(OP_LOAD, SIZE_HALF, 1'b0, bases[j] + off, 32'h0);
                send(OP_LOAD, SIZE_HALF, 1'b1, bases[j] + off, 32'h0);
            end
            send(OP_LOAD, SIZE_WORD, 1'b0, bases[j], 32'h0);
        end
        send(OP_STORE, SIZE_WORD, 1'b0, ERR_BASE + 8, take_bits(32));
        send(OP_LOAD, SIZE_WORD, 1'b0, ERR_BASE + 8, 32'h0);
        send(OP_LOAD, SIZE_BYTE, 1'b0, ERR_BASE + 9, 32'h0);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        if (n_pt > 0 && n_store > 0 && n_load > 0 && n_fault > 0 && n_clean > 0 && n_hold > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            report_error("a behavior was never exercised");
        end
    end

    // Watchdog
    initial begin
        #(NUM_TX * TX_CYCLES * 10);
        report_error("watchdog timeout, the DUT stopped responding");
    end

endmodule

`default_nettype wire

//--- tb_lsu_mem.sv
`default_nettype none

module tb_lsu_mem import lsu_pkg::*; #(
    parameter logic [31:0] ERR_BASE = 32'h3000_0000,
    parameter logic [31:0] ERR_END  = 32'h3000_00FF
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          ar_valid,
    output logic         ar_ready,
    input  wire axi_ax_t ar,
    input  wire          aw_valid,
    output logic         aw_ready,
    input  wire axi_ax_t aw,
    input  wire          w_valid,
    output logic         w_ready,
    input  wire axi_w_t  w,
    output logic         b_valid,
    input  wire          b_ready,
    output axi_b_t       b,
    output logic         r_valid,
    input  wire          r_ready,
    output axi_r_t       r
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [logic [31:0]];   // Keyed by word address
    logic [31:0] lfsr;
    logic        rd_pend;
    logic        wr_pend;
    logic        aw_got;
    logic        w_got;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;

    function automatic logic rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    // Contents of a word never written
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic in_err(input logic [31:0] a);
        return (a >= ERR_BASE) && (a <= ERR_END);
    endfunction

    initial begin
        lfsr     = 32'h80b7;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        r_valid  = 1'b0;
        b        = '0;
        r        = '0;
    end

    // ==============================
    // Handshakes seen on the rising edge
    // ==============================

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend = 1'b0;
            wr_pend = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_pend = 1'b1;
                rd_addr = ar.addr;
            end
            if (aw_valid && aw_ready) begin
                aw_got  = 1'b1;
                wr_addr = aw.addr;
            end
            if (w_valid && w_ready) begin
                w_got   = 1'b1;
                wr_data = w.data;
                wr_strb = w.strb;
            end
            if (r_valid && r_ready) rd_pend = 1'b0;
            if (b_valid && b_ready) wr_pend = 1'b0;
        end
    end

    // ==============================
    // Outputs driven on the falling edge
    // ==============================

    always @(negedge clk) begin
        logic [31:0] key;
        logic [31:0] word;
        if (rst) begin
            ar_ready = 1'b0;
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            b_valid  = 1'b0;
            r_valid  = 1'b0;
        end else begin
            ar_ready = rand_bit();
            aw_ready = rand_bit();
            w_ready  = rand_bit();
            if (r_valid && !rd_pend) begin
                r_valid = 1'b0;
            end else if (rd_pend && !r_valid && rand_bit()) begin
                key     = {rd_addr[31:2], 2'b00};
                r.data  = mem.exists(key) ? mem[key] : fill_word(key);
                r.resp  = in_err(rd_addr) ? 2'b10 : AXI_RESP_OKAY;  // SLVERR
                r.last  = 1'b1;
                r.id    = AXI_ID;
                r_valid = 1'b1;
            end
            if (b_valid && !wr_pend) begin
                b_valid = 1'b0;
            end else if (aw_got && w_got && !b_valid && rand_bit()) begin
                key = {wr_addr[31:2], 2'b00};
                if (!in_err(wr_addr)) begin
                    word = mem.exists(key) ? mem[key] : fill_word(key);
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) word[i*8 +: 8] = wr_data[i*8 +: 8];
                    end
                    mem[key] = word;
                end
                b.resp  = in_err(wr_addr) ? 2'b10 : AXI_RESP_OKAY;
                b.id    = AXI_ID;
                aw_got  = 1'b0;
                w_got   = 1'b0;
                wr_pend = 1'b1;
                b_valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
